// File: verilog/core_pkg.sv
package core_pkg;

  // data and address width
  parameter int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // one-hot alu code, all zero means add
  typedef logic [7:0] alu_op_t;

  localparam int alu_b_sub = 0;
  localparam int alu_b_xor = 1;
  localparam int alu_b_or  = 2;
  localparam int alu_b_and = 3;
  localparam int alu_b_sll = 4;
  localparam int alu_b_srl = 5;
  localparam int alu_b_sra = 6;

  typedef enum logic [1:0] {op2_reg, op2_imm} op2_sel_t;

  typedef enum logic [2:0] {npc_seq, npc_jal, npc_jalr, npc_branch, npc_trap, npc_mret} npc_sel_t;

  typedef enum logic [2:0] {wb_alu, wb_pc4, wb_load, wb_imm, wb_csr} wb_sel_t;

  typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_op_t;

  // same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

  localparam logic [11:0] csr_mtvec  = 12'h305;
  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  typedef struct packed {
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        rd_wen;
    wb_sel_t     wb_sel;
    op2_sel_t    op2_sel;
    // first alu operand is pc (auipc)
    logic        op1_pc;
    alu_op_t     alu_op;
    npc_sel_t    npc_sel;
    logic [2:0]  br_kind;
    logic        mem_ren;
    logic        mem_wen;
    mem_size_t   mem_size;
    logic        load_sext;
    csr_op_t     csr_op;
    logic [11:0] csr_addr;
    logic        ecall;
    logic        mret;
    logic        ebreak;
    logic        illegal;
  } ctrl_t;

  typedef struct packed {
    logic            ren;
    logic            wen;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wmask;
  } mem_req_t;

  typedef struct packed {
    logic            wen;
    reg_addr_t       rd;
    logic [xlen-1:0] data;
  } retire_t;

endpackage

// File: verilog/idu.sv
`timescale 1ns/1ps

module idu (
  input  logic [core_pkg::xlen-1:0] inst,
  output core_pkg::ctrl_t           ctrl,
  output logic [core_pkg::xlen-1:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic f7_zero, f7_alt;
  logic lui, auipc, jal, jalr, branch, load, store, op_imm, op, system;
  logic branch_ok, load_ok, store_ok, op_imm_ok, op_ok, arith;
  logic csr_rw, csr_rs, csr_rc, csr_any;
  logic ecall, mret, ebreak, legal;
  logic type_u, type_j, type_b, type_i, type_s;
  logic [core_pkg::xlen-1:0] imm_u, imm_j, imm_b, imm_i, imm_s;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign f7_zero = funct7 == 7'b00000_00;
  assign f7_alt  = funct7 == 7'b01000_00;

  assign lui    = opcode == 7'b01_101_11;
  assign auipc  = opcode == 7'b00_101_11;
  assign jal    = opcode == 7'b11_011_11;
  assign jalr   = opcode == 7'b11_001_11 && funct3 == 3'b000;
  assign branch = opcode == 7'b11_000_11;
  assign load   = opcode == 7'b00_000_11;
  assign store  = opcode == 7'b01_000_11;
  assign op_imm = opcode == 7'b00_100_11;
  assign op     = opcode == 7'b01_100_11;
  assign system = opcode == 7'b11_100_11;

  // funct3 values 010 and 011 are not branches
  assign branch_ok = funct3[2] || funct3[1:0] < 2'b10;
  assign load_ok   = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010
                  || funct3 == 3'b100 || funct3 == 3'b101;
  assign store_ok  = funct3 < 3'b011;

  // shift-immediates carry funct7 in the upper imm bits
  assign op_imm_ok = (funct3 != 3'b001 && funct3 != 3'b101)
                  || (funct3 == 3'b001 && f7_zero)
                  || (funct3 == 3'b101 && (f7_zero || f7_alt));
  assign op_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  assign arith = (op && op_ok) || (op_imm && op_imm_ok);

  assign csr_rw  = system && funct3 == 3'b001;
  assign csr_rs  = system && funct3 == 3'b010;
  assign csr_rc  = system && funct3 == 3'b011;
  assign csr_any = csr_rw || csr_rs || csr_rc;

  assign ecall  = inst == 32'b0000000_00000_00000_000_00000_11100_11;
  assign ebreak = inst == 32'b0000000_00001_00000_000_00000_11100_11;
  assign mret   = inst == 32'b0011000_00010_00000_000_00000_11100_11;

  assign legal = lui || auipc || jal || jalr || (branch && branch_ok) || (load && load_ok)
              || (store && store_ok) || arith || csr_any || ecall || mret || ebreak;

  assign type_u = lui || auipc;
  assign type_j = jal;
  assign type_b = branch;
  assign type_i = jalr || load || op_imm;
  assign type_s = store;

  assign imm_u = type_u ? {inst[31:12], 12'b0} : '0;
  assign imm_j = type_j ? {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} : '0;
  assign imm_b = type_b ? {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0} : '0;
  assign imm_i = type_i ? {{20{inst[31]}}, inst[31:20]} : '0;
  assign imm_s = type_s ? {{20{inst[31]}}, inst[31:25], inst[11:7]} : '0;

  assign imm = imm_u | imm_j | imm_b | imm_i | imm_s;

  always_comb begin
    ctrl = '0;
    // lui reads x0 so the rs1 port stays idle
    ctrl.rs1 = lui ? 5'd0 : inst[19:15];
    ctrl.rs2 = inst[24:20];
    ctrl.rd  = inst[11:7];
    ctrl.rd_wen = lui || auipc || jal || jalr || (load && load_ok) || arith || csr_any;

    if (lui) begin
      ctrl.wb_sel = core_pkg::wb_imm;
    end else if (jal || jalr) begin
      ctrl.wb_sel = core_pkg::wb_pc4;
    end else if (load) begin
      ctrl.wb_sel = core_pkg::wb_load;
    end else if (csr_any) begin
      ctrl.wb_sel = core_pkg::wb_csr;
    end else begin
      ctrl.wb_sel = core_pkg::wb_alu;
    end

    ctrl.op2_sel = (op || branch) ? core_pkg::op2_reg : core_pkg::op2_imm;
    ctrl.op1_pc  = auipc;

    // compare also covers branches and slt/sltu, exu tells them apart by funct3
    ctrl.alu_op[core_pkg::alu_b_sub] = (op && funct3 == 3'b000 && inst[30]) || branch
                                    || ((op || op_imm) && funct3[2:1] == 2'b01);
    ctrl.alu_op[core_pkg::alu_b_xor] = (op || op_imm) && funct3 == 3'b100;
    ctrl.alu_op[core_pkg::alu_b_or]  = (op || op_imm) && funct3 == 3'b110;
    ctrl.alu_op[core_pkg::alu_b_and] = (op || op_imm) && funct3 == 3'b111;
    ctrl.alu_op[core_pkg::alu_b_sll] = (op || op_imm) && funct3 == 3'b001;
    ctrl.alu_op[core_pkg::alu_b_srl] = (op || op_imm) && funct3 == 3'b101 && !inst[30];
    ctrl.alu_op[core_pkg::alu_b_sra] = (op || op_imm) && funct3 == 3'b101 && inst[30];

    if (jal) begin
      ctrl.npc_sel = core_pkg::npc_jal;
    end else if (jalr) begin
      ctrl.npc_sel = core_pkg::npc_jalr;
    end else if (branch && branch_ok) begin
      ctrl.npc_sel = core_pkg::npc_branch;
    end else if (ecall) begin
      ctrl.npc_sel = core_pkg::npc_trap;
    end else if (mret) begin
      ctrl.npc_sel = core_pkg::npc_mret;
    end else begin
      ctrl.npc_sel = core_pkg::npc_seq;
    end

    ctrl.br_kind   = funct3;
    ctrl.mem_ren   = load && load_ok;
    ctrl.mem_wen   = store && store_ok;
    ctrl.mem_size  = core_pkg::mem_size_t'(funct3[1:0]);
    ctrl.load_sext = !funct3[2];

    if (csr_rw) begin
      ctrl.csr_op = core_pkg::csr_write;
    end else if (csr_rs) begin
      ctrl.csr_op = core_pkg::csr_set;
    end else if (csr_rc) begin
      ctrl.csr_op = core_pkg::csr_clear;
    end else begin
      ctrl.csr_op = core_pkg::csr_none;
    end
    ctrl.csr_addr = inst[31:20];

    ctrl.ecall   = ecall;
    ctrl.mret    = mret;
    ctrl.ebreak  = ebreak;
    ctrl.illegal = !legal;
  end

endmodule

// File: verilog/exu.sv
`timescale 1ns/1ps

module exu (
  input  core_pkg::ctrl_t           ctrl,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  input  logic [core_pkg::xlen-1:0] imm,
  input  logic [core_pkg::xlen-1:0] pc,
  input  logic [core_pkg::xlen-1:0] csr_old,
  output logic [core_pkg::xlen-1:0] alu_result,
  output logic                      branch_taken,
  output logic [core_pkg::xlen-1:0] csr_new
);

  logic [core_pkg::xlen-1:0] op1, op2;
  logic [4:0] shamt;
  logic slt, sltu;
  logic br_eq, br_lt, br_ltu;

  assign op1   = ctrl.op1_pc ? pc : rs1_data;
  assign op2   = (ctrl.op2_sel == core_pkg::op2_imm) ? imm : rs2_data;
  assign shamt = op2[4:0];

  assign slt  = $signed(op1) < $signed(op2);
  assign sltu = op1 < op2;

  always_comb begin
    if (ctrl.alu_op[core_pkg::alu_b_sub]) begin
      // funct3 picks set-less-than over a plain subtract
      case (ctrl.br_kind)
        3'b010:  alu_result = {31'b0, slt};
        3'b011:  alu_result = {31'b0, sltu};
        default: alu_result = op1 - op2;
      endcase
    end else if (ctrl.alu_op[core_pkg::alu_b_xor]) begin
      alu_result = op1 ^ op2;
    end else if (ctrl.alu_op[core_pkg::alu_b_or]) begin
      alu_result = op1 | op2;
    end else if (ctrl.alu_op[core_pkg::alu_b_and]) begin
      alu_result = op1 & op2;
    end else if (ctrl.alu_op[core_pkg::alu_b_sll]) begin
      alu_result = op1 << shamt;
    end else if (ctrl.alu_op[core_pkg::alu_b_srl]) begin
      alu_result = op1 >> shamt;
    end else if (ctrl.alu_op[core_pkg::alu_b_sra]) begin
      alu_result = $signed(op1) >>> shamt;
    end else begin
      alu_result = op1 + op2;
    end
  end

  // branches always compare the two source registers
  assign br_eq  = rs1_data == rs2_data;
  assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu = rs1_data < rs2_data;

  always_comb begin
    case (ctrl.br_kind)
      3'b000:  branch_taken = br_eq;
      3'b001:  branch_taken = !br_eq;
      3'b100:  branch_taken = br_lt;
      3'b101:  branch_taken = !br_lt;
      3'b110:  branch_taken = br_ltu;
      3'b111:  branch_taken = !br_ltu;
      default: branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.csr_op)
      core_pkg::csr_write: csr_new = rs1_data;
      core_pkg::csr_set:   csr_new = csr_old | rs1_data;
      core_pkg::csr_clear: csr_new = csr_old & ~rs1_data;
      default:             csr_new = csr_old;
    endcase
  end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                      clock,
  input  logic                      reset,
  input  core_pkg::reg_addr_t       raddr1,
  input  core_pkg::reg_addr_t       raddr2,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2,
  input  logic                      wen,
  input  core_pkg::reg_addr_t       waddr,
  input  logic [core_pkg::xlen-1:0] wdata
);

  logic [core_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      // x0 is never written
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read, x0 reads as zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                      clock,
  input  logic                      reset,
  input  core_pkg::csr_op_t         csr_op,
  input  logic [11:0]               csr_addr,
  input  logic [core_pkg::xlen-1:0] csr_new,
  input  logic                      ecall,
  input  logic [core_pkg::xlen-1:0] pc,
  output logic [core_pkg::xlen-1:0] csr_old,
  output logic [core_pkg::xlen-1:0] mtvec,
  output logic [core_pkg::xlen-1:0] mepc
);

  // environment call from m-mode
  localparam logic [core_pkg::xlen-1:0] cause_ecall_m = 32'd11;

  logic [core_pkg::xlen-1:0] mcause;

  always_comb begin
    case (csr_addr)
      core_pkg::csr_mtvec:  csr_old = mtvec;
      core_pkg::csr_mepc:   csr_old = mepc;
      core_pkg::csr_mcause: csr_old = mcause;
      default:              csr_old = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else begin
      if (csr_op != core_pkg::csr_none) begin
        case (csr_addr)
          core_pkg::csr_mtvec:  mtvec  <= csr_new;
          core_pkg::csr_mepc:   mepc   <= csr_new;
          core_pkg::csr_mcause: mcause <= csr_new;
          default: ;
        endcase
      end
      // trap entry, never in the same cycle as a csr instruction
      if (ecall) begin
        mepc   <= pc;
        mcause <= cause_ecall_m;
      end
    end
  end

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      active,
  input  core_pkg::ctrl_t           ctrl,
  input  logic                      branch_taken,
  input  logic [core_pkg::xlen-1:0] imm,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] mtvec,
  input  logic [core_pkg::xlen-1:0] mepc,
  output logic [core_pkg::xlen-1:0] pc,
  output logic                      halt
);

  logic [core_pkg::xlen-1:0] pc_plus4, pc_rel, jalr_target, next_pc;

  assign pc_plus4    = pc + 32'd4;
  assign pc_rel      = pc + imm;
  assign jalr_target = (rs1_data + imm) & ~32'd1;

  always_comb begin
    case (ctrl.npc_sel)
      core_pkg::npc_jal:    next_pc = pc_rel;
      core_pkg::npc_jalr:   next_pc = jalr_target;
      core_pkg::npc_branch: next_pc = branch_taken ? pc_rel : pc_plus4;
      core_pkg::npc_trap:   next_pc = mtvec;
      core_pkg::npc_mret:   next_pc = mepc;
      default:              next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (active) begin
      pc <= next_pc;
      // sticky until reset
      if (ctrl.ebreak) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  core_pkg::ctrl_t           ctrl,
  input  logic                      ren,
  input  logic                      wen,
  input  logic [core_pkg::xlen-1:0] addr,
  input  logic [core_pkg::xlen-1:0] store_data,
  input  logic [core_pkg::xlen-1:0] mem_rdata,
  output core_pkg::mem_req_t        mem_req,
  output logic [core_pkg::xlen-1:0] load_data
);

  logic [1:0] lane;
  logic [3:0] mask;
  logic [4:0] shamt;
  logic [core_pkg::xlen-1:0] lane_data;

  always_comb begin
    case (ctrl.mem_size)
      core_pkg::size_byte: begin
        lane = addr[1:0];
        mask = 4'b0001;
      end
      core_pkg::size_half: begin
        lane = {addr[1], 1'b0};
        mask = 4'b0011;
      end
      default: begin
        lane = 2'b00;
        mask = 4'b1111;
      end
    endcase
  end

  assign shamt = {lane, 3'b000};

  // word address leaves the core, the byte offset lives in wmask
  assign mem_req.ren   = ren;
  assign mem_req.wen   = wen;
  assign mem_req.addr  = {addr[31:2], 2'b00};
  assign mem_req.wdata = store_data << shamt;
  assign mem_req.wmask = wen ? (mask << lane) : 4'b0000;

  assign lane_data = mem_rdata >> shamt;

  always_comb begin
    case (ctrl.mem_size)
      core_pkg::size_byte:
        load_data = {{24{ctrl.load_sext & lane_data[7]}}, lane_data[7:0]};
      core_pkg::size_half:
        load_data = {{16{ctrl.load_sext & lane_data[15]}}, lane_data[15:0]};
      default:
        load_data = lane_data;
    endcase
  end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [core_pkg::xlen-1:0] inst,
  input  logic                      ivalid,
  input  logic [core_pkg::xlen-1:0] mem_rdata,
  output logic [core_pkg::xlen-1:0] pc,
  output core_pkg::mem_req_t        mem_req,
  output core_pkg::retire_t         retire,
  output logic                      halt
);

  core_pkg::ctrl_t ctrl;
  core_pkg::csr_op_t csr_op;
  logic active;
  logic ecall_en;
  logic branch_taken;
  logic [core_pkg::xlen-1:0] imm, rs1_data, rs2_data, alu_result;
  logic [core_pkg::xlen-1:0] csr_new, csr_old, mtvec, mepc;
  logic [core_pkg::xlen-1:0] load_data, wb_data;

  // one instruction commits per valid cycle until ebreak
  assign active   = ivalid && !halt;
  assign csr_op   = active ? ctrl.csr_op : core_pkg::csr_none;
  assign ecall_en = active && ctrl.ecall;

  idu i_idu (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  regfile i_regfile (
    .clock  (clock),
    .reset  (reset),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .wen    (retire.wen),
    .waddr  (retire.rd),
    .wdata  (retire.data)
  );

  exu i_exu (
    .ctrl         (ctrl),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .pc           (pc),
    .csr_old      (csr_old),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .csr_new      (csr_new)
  );

  lsu i_lsu (
    .ctrl       (ctrl),
    .ren        (active && ctrl.mem_ren),
    .wen        (active && ctrl.mem_wen),
    .addr       (alu_result),
    .store_data (rs2_data),
    .mem_rdata  (mem_rdata),
    .mem_req    (mem_req),
    .load_data  (load_data)
  );

  csr_file i_csr_file (
    .clock    (clock),
    .reset    (reset),
    .csr_op   (csr_op),
    .csr_addr (ctrl.csr_addr),
    .csr_new  (csr_new),
    .ecall    (ecall_en),
    .pc       (pc),
    .csr_old  (csr_old),
    .mtvec    (mtvec),
    .mepc     (mepc)
  );

  pc_unit #(
    .reset_pc (reset_pc)
  ) i_pc_unit (
    .clock        (clock),
    .reset        (reset),
    .active       (active),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .pc           (pc),
    .halt         (halt)
  );

  // write-back source
  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_pc4:  wb_data = pc + 32'd4;
      core_pkg::wb_load: wb_data = load_data;
      core_pkg::wb_imm:  wb_data = imm;
      core_pkg::wb_csr:  wb_data = csr_old;
      default:           wb_data = alu_result;
    endcase
  end

  assign retire.wen  = active && ctrl.rd_wen;
  assign retire.rd   = ctrl.rd;
  assign retire.data = wb_data;

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  localparam logic [31:0] reset_pc = 32'h100;
  localparam int n_fill = 62;
  localparam int n_alu  = 200;
  localparam int n_flow = 80;
  localparam int n_mem  = 120;
  localparam int n_csr  = 60;
  localparam int n_halt = 90;
  // resets and the idle cycle closing each test
  localparam int n_cycles = n_fill + n_alu + n_flow + n_mem + n_csr + n_halt + 30;

  logic clock = 1'b0;
  logic reset;
  logic [31:0] inst;
  logic ivalid;
  logic [31:0] mem_rdata;
  logic [31:0] pc;
  core_pkg::mem_req_t mem_req;
  core_pkg::retire_t retire;
  logic halt;

  logic [31:0] dmem [64];
  logic [31:0] seed = 32'hde7861fb;
  int errors = 0;
  int checks = 0;
  int errors_before;

  // architectural state of the reference model
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic m_halt;
  core_pkg::retire_t exp_retire;
  core_pkg::mem_req_t exp_req;

  core_top #(
    .reset_pc (reset_pc)
  ) i_dut (
    .clock     (clock),
    .reset     (reset),
    .inst      (inst),
    .ivalid    (ivalid),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_req   (mem_req),
    .retire    (retire),
    .halt      (halt)
  );

  always #10 clock = ~clock;

  // data memory, word indexed, answers in the same cycle
  assign mem_rdata = dmem[mem_req.addr[7:2]];

  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= (i * 32'h9e3779b1) ^ {i[7:0], 24'h5a3c96} ^ (i << 2);
      end
    end else if (mem_req.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req.wmask[b]) begin
          dmem[mem_req.addr[7:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("** Error: %s got 0x%08h, expected 0x%08h at %0d ns", name, got, exp, $time);
  endtask

  task automatic check_retire(input core_pkg::retire_t got, input core_pkg::retire_t exp);
    checks++;
    if (got.wen !== exp.wen) begin
      mismatch("retire.wen", 32'(got.wen), 32'(exp.wen));
    end else if (exp.wen && got.rd !== exp.rd) begin
      mismatch("retire.rd", 32'(got.rd), 32'(exp.rd));
    end else if (exp.wen && got.data !== exp.data) begin
      mismatch("retire.data", got.data, exp.data);
    end
  endtask

  task automatic check_mem_req(input core_pkg::mem_req_t got, input core_pkg::mem_req_t exp);
    checks++;
    if (got.ren !== exp.ren) begin
      mismatch("mem_req.ren", 32'(got.ren), 32'(exp.ren));
    end else if (got.wen !== exp.wen) begin
      mismatch("mem_req.wen", 32'(got.wen), 32'(exp.wen));
    end else if ((exp.ren || exp.wen) && got.addr !== exp.addr) begin
      mismatch("mem_req.addr", got.addr, exp.addr);
    end else if (exp.wen && got.wmask !== exp.wmask) begin
      mismatch("mem_req.wmask", 32'(got.wmask), 32'(exp.wmask));
    end else if (exp.wen && (got.wdata & lane_mask(exp.wmask))
                 !== (exp.wdata & lane_mask(exp.wmask))) begin
      mismatch("mem_req.wdata", got.wdata, exp.wdata);
    end
  endtask

  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatch("pc", got, exp);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatch("halt", 32'(got), 32'(exp));
    end
  endtask

  function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = reset_pc;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_halt = 1'b0;
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      12'h305: return m_mtvec;
      12'h341: return m_mepc;
      12'h342: return m_mcause;
      default: return 32'd0;
    endcase
  endfunction

  function automatic void csr_write(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
      12'h305: m_mtvec = value;
      12'h341: m_mepc = value;
      12'h342: m_mcause = value;
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic signed [31:0] sx;
    sx = x;
    case (f3)
      3'b000: return alt ? x - y : x + y;
      3'b001: return x << y[4:0];
      3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011: return (x < y) ? 32'd1 : 32'd0;
      3'b100: return x ^ y;
      3'b101: begin
        if (alt) begin
          return sx >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'b110: return x | y;
      default: return x & y;
    endcase
  endfunction

  // executes one instruction on the model state
  function automatic void ref_step(input logic [31:0] w, input logic valid,
                                   output core_pkg::retire_t er,
                                   output core_pkg::mem_req_t eq);
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [31:0] npc, val, addr, word, old;
    logic [2:0] f3;
    logic wr, taken;
    er = '0;
    eq = '0;
    if (!valid || m_halt) begin
      return;
    end
    f3 = w[14:12];
    a = m_regs[w[19:15]];
    b = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'b0};
    npc = m_pc + 32'd4;
    val = '0;
    wr = 1'b0;
    case (w[6:0])
      7'b0110111: begin
        wr = 1'b1;
        val = imm_u;
      end
      7'b0010111: begin
        wr = 1'b1;
        val = m_pc + imm_u;
      end
      7'b1101111: begin
        wr = 1'b1;
        val = m_pc + 32'd4;
        npc = m_pc + imm_j;
      end
      7'b1100111: begin
        wr = 1'b1;
        val = m_pc + 32'd4;
        npc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        case (f3)
          3'b000: taken = a == b;
          3'b001: taken = a != b;
          3'b100: taken = $signed(a) < $signed(b);
          3'b101: taken = $signed(a) >= $signed(b);
          3'b110: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) begin
          npc = m_pc + imm_b;
        end
      end
      7'b0000011: begin
        addr = a + imm_i;
        eq.ren = 1'b1;
        eq.addr = {addr[31:2], 2'b00};
        word = dmem[addr[7:2]] >> {addr[1:0], 3'b000};
        case (f3)
          3'b000: val = {{24{word[7]}}, word[7:0]};
          3'b001: val = {{16{word[15]}}, word[15:0]};
          3'b100: val = {24'b0, word[7:0]};
          3'b101: val = {16'b0, word[15:0]};
          default: val = word;
        endcase
        wr = 1'b1;
      end
      7'b0100011: begin
        addr = a + imm_s;
        eq.wen = 1'b1;
        eq.addr = {addr[31:2], 2'b00};
        eq.wdata = b << {addr[1:0], 3'b000};
        case (f3)
          3'b000: eq.wmask = 4'b0001 << addr[1:0];
          3'b001: eq.wmask = 4'b0011 << addr[1:0];
          default: eq.wmask = 4'b1111;
        endcase
      end
      7'b0010011: begin
        wr = 1'b1;
        val = alu_ref(f3, f3 == 3'b101 && w[30], a, imm_i);
      end
      7'b0110011: begin
        wr = 1'b1;
        val = alu_ref(f3, w[30], a, b);
      end
      7'b1110011: begin
        if (f3 != 3'b000) begin
          old = csr_read(w[31:20]);
          case (f3[1:0])
            2'b01: csr_write(w[31:20], a);
            2'b10: csr_write(w[31:20], old | a);
            default: csr_write(w[31:20], old & ~a);
          endcase
          wr = 1'b1;
          val = old;
        end else if (w[31:20] == 12'h000) begin
          npc = m_mtvec;
          m_mepc = m_pc;
          m_mcause = 32'd11;
        end else if (w[31:20] == 12'h302) begin
          npc = m_mepc;
        end else if (w[31:20] == 12'h001) begin
          m_halt = 1'b1;
        end
      end
      default: ;
    endcase
    if (wr) begin
      er.wen = 1'b1;
      er.rd = w[11:7];
      er.data = val;
      if (w[11:7] != 5'd0) begin
        m_regs[w[11:7]] = val;
      end
    end
    m_pc = npc;
  endfunction

  // outputs are settled half a period after the inputs change
  always @(negedge clock) begin
    if (reset) begin
      model_reset();
    end else begin
      check_pc(pc, m_pc);
      check_halt(halt, m_halt);
      ref_step(inst, ivalid, exp_retire, exp_req);
      check_retire(retire, exp_retire);
      check_mem_req(mem_req, exp_req);
    end
  end

  function automatic logic [31:0] gen_alu();
    logic [31:0] r, k;
    logic [2:0] f3;
    logic [11:0] imm;
    r = next_rand();
    k = next_rand();
    f3 = r[14:12];
    case (k[31:30])
      2'd0: begin
        if (k[29] && (f3 == 3'b000 || f3 == 3'b101)) begin
          return {7'h20, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
        end
        return {7'h00, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
      end
      2'd1: begin
        imm = r[31:20];
        if (f3 == 3'b001) begin
          imm = {7'h00, r[24:20]};
        end else if (f3 == 3'b101) begin
          imm = {k[29] ? 7'h20 : 7'h00, r[24:20]};
        end
        return {imm, r[19:15], f3, r[11:7], 7'b0010011};
      end
      2'd2: return {r[31:12], r[11:7], 7'b0110111};
      default: return {r[31:12], r[11:7], 7'b0010111};
    endcase
  endfunction

  function automatic logic [31:0] gen_flow();
    logic [31:0] r, k;
    logic [4:0] rs2;
    logic [2:0] f3;
    r = next_rand();
    k = next_rand();
    f3 = k[29:27];
    // 010 and 011 are no branch kinds
    if (f3 == 3'b010 || f3 == 3'b011) begin
      f3 = f3 + 3'd2;
    end
    rs2 = k[26] ? r[19:15] : r[24:20];
    case (k[31:30])
      2'd0, 2'd1: return {r[31:25], rs2, r[19:15], f3, r[11:7], 7'b1100011};
      2'd2: return {r[31:12], r[11:7], 7'b1101111};
      default: return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b1100111};
    endcase
  endfunction

  // loads and stores, the offset keeps every access naturally aligned
  function automatic logic [31:0] gen_mem();
    logic [31:0] r, k, base;
    logic [1:0] sz, lo, off;
    logic [11:0] imm;
    r = next_rand();
    k = next_rand();
    base = m_regs[r[19:15]];
    sz = (k[31:30] == 2'd3) ? 2'd2 : k[31:30];
    case (sz)
      2'd0: lo = k[25:24];
      2'd1: lo = {k[25], 1'b0};
      default: lo = 2'b00;
    endcase
    off = lo - base[1:0];
    imm = {r[31:22], off};
    if (k[27]) begin
      return {imm[11:5], r[24:20], r[19:15], 1'b0, sz, imm[4:0], 7'b0100011};
    end
    return {imm, r[19:15], (k[28] && sz != 2'd2), sz, r[11:7], 7'b0000011};
  endfunction

  function automatic logic [31:0] gen_csr();
    logic [31:0] r, k;
    logic [11:0] addr;
    logic [2:0] f3;
    r = next_rand();
    k = next_rand();
    case (k[28:27])
      2'd0: addr = 12'h305;
      2'd1: addr = 12'h341;
      2'd2: addr = 12'h342;
      default: addr = 12'h340;
    endcase
    f3 = (k[26:25] == 2'd0) ? 3'b001 : {1'b0, k[26:25]};
    case (k[31:29])
      3'd0: return 32'h00000073;
      3'd1: return 32'h30200073;
      default: return {addr, r[19:15], f3, r[11:7], 7'b1110011};
    endcase
  endfunction

  task automatic drive(input logic [31:0] word, input logic valid);
    inst <= word;
    ivalid <= valid;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      drive(next_rand(), 1'b0);
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clock);
    drive(32'h00000013, 1'b0);
    $display("test %s: %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    drive(32'h00000013, 1'b0);
    repeat (5) @(posedge clock);
    reset <= 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    inst = 32'h00000013;
    ivalid = 1'b0;
    reset = 1'b1;
    errors_before = 0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    idle(3);
    end_test("reset state");

    // give every register a random value first
    for (int r = 1; r < 32; r++) begin
      rnd = next_rand();
      @(posedge clock);
      drive({rnd[31:12], 5'(r), 7'b0110111}, 1'b1);
      @(posedge clock);
      drive({rnd[11:0], 5'(r), 3'b000, 5'(r), 7'b0010011}, 1'b1);
    end
    repeat (n_alu) begin
      @(posedge clock);
      drive(gen_alu(), 1'b1);
    end
    end_test("alu");

    repeat (n_flow) begin
      @(posedge clock);
      drive(gen_flow(), 1'b1);
    end
    end_test("branch and jump");

    repeat (n_mem) begin
      @(posedge clock);
      drive(gen_mem(), 1'b1);
    end
    end_test("load and store");

    repeat (n_csr) begin
      @(posedge clock);
      drive(gen_csr(), 1'b1);
    end
    end_test("csr and trap");

    for (int i = 0; i < 20; i++) begin
      @(posedge clock);
      drive(next_rand(), 1'b0);
      @(posedge clock);
      drive(gen_alu(), 1'b1);
    end
    @(posedge clock);
    drive(32'h00100073, 1'b1);
    for (int i = 0; i < 30; i++) begin
      @(posedge clock);
      if (i % 2 == 0) begin
        drive(gen_mem(), 1'b1);
      end else begin
        drive(gen_alu(), 1'b1);
      end
    end
    apply_reset();
    repeat (10) begin
      @(posedge clock);
      drive(gen_alu(), 1'b1);
    end
    end_test("idle and halt");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(n_cycles * 40 + 1000);
    $display("watchdog expired after %0d ns, the tests did not complete", $time);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: compile.f
verilog/core_pkg.sv
verilog/idu.sv
verilog/exu.sv
verilog/regfile.sv
verilog/csr_file.sv
verilog/pc_unit.sv
verilog/lsu.sv
verilog/core_top.sv
test/core_tb.sv

// File: Makefile
SRCS = $(shell cat compile.f)

all: check

obj_dir/Vcore_tb: compile.f $(SRCS)
	verilator --binary --timing --top-module core_tb -f compile.f -o Vcore_tb

run: obj_dir/Vcore_tb
	obj_dir/Vcore_tb | tee sim.log
	grep -q '^RESULT: PASS$$' sim.log

check: sim.log
	grep -q '^RESULT: PASS$$' sim.log

sim.log: obj_dir/Vcore_tb
	obj_dir/Vcore_tb > sim.log || true

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
